/* cpu_pkg.sv */
// shared cpu types
`default_nettype none

package cpu_pkg;

  typedef logic [63:0] word_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;

  // decoded instruction class
  typedef enum logic [2:0] {
    op_alu_reg,
    op_alu_imm,
    op_lui,
    op_load,
    op_store,
    op_branch,
    op_putch,
    op_none
  } op_kind_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt
  } alu_op_e;

  // major opcodes of the supported subset
  localparam logic [6:0] opc_op     = 7'h33;
  localparam logic [6:0] opc_op_imm = 7'h13;
  localparam logic [6:0] opc_lui    = 7'h37;
  localparam logic [6:0] opc_load   = 7'h03;
  localparam logic [6:0] opc_store  = 7'h23;
  localparam logic [6:0] opc_branch = 7'h63;
  // custom-3 space, low byte of rs1 to the serial port
  localparam logic [6:0] opc_putch  = 7'h7b;

  // addi x0, x0, 0
  localparam inst_t nop_inst = 32'h0000_0013;

endpackage

`default_nettype wire

/* if_stage.sv */
// instruction fetch stage
`default_nettype none

module if_stage
  import cpu_pkg::*;
#(
  parameter word_t RESET_PC = 64'h0000_0000_8000_0000
) (
  input  logic  clock,
  input  logic  reset,
  input  logic  id_allowin,
  input  logic  branch_taken,
  input  word_t branch_target,
  output logic  if_to_id_valid,
  output word_t if_to_id_pc,
  output inst_t if_to_id_inst,
  output logic  if_rw_valid,
  input  logic  if_rw_ready,
  output word_t if_rw_addr,
  input  inst_t if_r_data
);

  logic  req_q;
  logic  drop_q;
  logic  buf_valid;
  word_t fetch_pc;
  word_t target_q;
  word_t buf_pc;
  inst_t buf_inst;
  logic  fire;
  logic  fill;
  logic  accept;
  logic  buf_busy;

  assign fire   = req_q & if_rw_ready;
  // a redirect or a stale request never reaches the holding register
  assign fill   = fire & ~drop_q & ~branch_taken;
  assign accept = buf_valid & id_allowin;
  // holding register still occupied next cycle
  assign buf_busy = fill | (buf_valid & ~accept & ~branch_taken);

  always_ff @(posedge clock) begin
    if (reset) begin
      req_q     <= 1'b0;
      drop_q    <= 1'b0;
      buf_valid <= 1'b0;
      fetch_pc  <= RESET_PC;
    end else begin
      buf_valid <= buf_busy;
      // one request at a time, only into an empty holding register
      if (!req_q || fire) begin
        req_q <= ~buf_busy;
      end
      if (branch_taken && req_q && !fire) begin
        // finish the outstanding fetch first, then go to the target
        drop_q <= 1'b1;
      end else if (fire && drop_q) begin
        drop_q   <= 1'b0;
        fetch_pc <= target_q;
      end else if (branch_taken) begin
        fetch_pc <= branch_target;
      end else if (fill) begin
        fetch_pc <= fetch_pc + 64'd4;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (branch_taken) begin
      target_q <= branch_target;
    end
    if (fill) begin
      buf_pc   <= fetch_pc;
      buf_inst <= if_r_data;
    end
  end

  assign if_rw_valid    = req_q;
  assign if_rw_addr     = fetch_pc;
  assign if_to_id_valid = buf_valid;
  assign if_to_id_pc    = buf_pc;
  assign if_to_id_inst  = buf_inst;

endmodule

`default_nettype wire

/* id_stage.sv */
// instruction decode stage
`default_nettype none

module id_stage
  import cpu_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     if_to_id_valid,
  input  word_t    if_to_id_pc,
  input  inst_t    if_to_id_inst,
  output logic     id_allowin,
  input  logic     ex_allowin,
  output logic     id_to_ex_valid,
  output word_t    id_to_ex_pc,
  output op_kind_e id_to_ex_kind,
  output alu_op_e  id_to_ex_alu_op,
  output reg_idx_t id_to_ex_dest,
  output word_t    id_to_ex_a,
  output word_t    id_to_ex_b,
  output word_t    id_to_ex_store_data,
  output reg_idx_t rs1_addr,
  output reg_idx_t rs2_addr,
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  input  logic     ex_pend_valid,
  input  reg_idx_t ex_pend_dest,
  input  logic     mem_pend_valid,
  input  reg_idx_t mem_pend_dest,
  input  logic     wb_pend_valid,
  input  reg_idx_t wb_pend_dest,
  output logic     branch_taken,
  output word_t    branch_target
);

  logic       id_valid;
  word_t      id_pc;
  inst_t      id_inst;
  logic [6:0] opcode;
  logic [2:0] funct3;
  op_kind_e   kind;
  alu_op_e    alu_op;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  logic       use_rs1;
  logic       use_rs2;
  logic       writes_rd;
  logic       rs1_busy;
  logic       rs2_busy;
  logic       ready_go;
  logic       cond;

  function automatic logic pend_hit(input logic pv, input reg_idx_t pd, input reg_idx_t src);
    return pv && (pd == src) && (src != '0);
  endfunction

  assign opcode   = id_inst[6:0];
  assign funct3   = id_inst[14:12];
  assign rs1_addr = id_inst[19:15];
  assign rs2_addr = id_inst[24:20];

  assign imm_i = {{52{id_inst[31]}}, id_inst[31:20]};
  assign imm_s = {{52{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
  assign imm_b = {{51{id_inst[31]}}, id_inst[31], id_inst[7], id_inst[30:25],
                  id_inst[11:8], 1'b0};
  assign imm_u = {{32{id_inst[31]}}, id_inst[31:12], 12'h000};

  // unsupported encodings fall to op_none
  always_comb begin
    kind   = op_none;
    alu_op = alu_add;
    case (opcode)
      opc_op: begin
        kind = op_alu_reg;
        case (funct3)
          3'b000:  alu_op = id_inst[30] ? alu_sub : alu_add;
          3'b010:  alu_op = alu_slt;
          3'b100:  alu_op = alu_xor;
          3'b110:  alu_op = alu_or;
          3'b111:  alu_op = alu_and;
          default: kind = op_none;
        endcase
      end
      opc_op_imm: if (funct3 == 3'b000) kind = op_alu_imm;
      opc_lui:    kind = op_lui;
      opc_load:   if (funct3 == 3'b011) kind = op_load;
      opc_store:  if (funct3 == 3'b011) kind = op_store;
      opc_branch: if (funct3[2:1] == 2'b00) kind = op_branch;
      opc_putch:  kind = op_putch;
      default:    kind = op_none;
    endcase
  end

  assign use_rs1   = (kind != op_lui) && (kind != op_none);
  assign use_rs2   = kind inside {op_alu_reg, op_store, op_branch};
  assign writes_rd = kind inside {op_alu_reg, op_alu_imm, op_lui, op_load};

  // raw interlock against every younger-than-regfile writer
  assign rs1_busy = use_rs1 && (pend_hit(ex_pend_valid, ex_pend_dest, rs1_addr) ||
                                pend_hit(mem_pend_valid, mem_pend_dest, rs1_addr) ||
                                pend_hit(wb_pend_valid, wb_pend_dest, rs1_addr));
  assign rs2_busy = use_rs2 && (pend_hit(ex_pend_valid, ex_pend_dest, rs2_addr) ||
                                pend_hit(mem_pend_valid, mem_pend_dest, rs2_addr) ||
                                pend_hit(wb_pend_valid, wb_pend_dest, rs2_addr));
  assign ready_go = ~rs1_busy & ~rs2_busy;

  assign id_allowin     = ~id_valid | (ready_go & ex_allowin);
  assign id_to_ex_valid = id_valid & ready_go;

  // beq on funct3 000, bne on 001
  assign cond          = funct3[0] ? (rs1_data != rs2_data) : (rs1_data == rs2_data);
  assign branch_taken  = id_valid && ready_go && ex_allowin && (kind == op_branch) && cond;
  assign branch_target = id_pc + imm_b;

  always_comb begin
    case (kind)
      op_alu_reg:                  id_to_ex_b = rs2_data;
      op_store:                    id_to_ex_b = imm_s;
      op_lui:                      id_to_ex_b = imm_u;
      op_putch, op_branch, op_none: id_to_ex_b = '0;
      default:                     id_to_ex_b = imm_i;
    endcase
  end

  assign id_to_ex_pc         = id_pc;
  assign id_to_ex_kind       = kind;
  assign id_to_ex_alu_op     = alu_op;
  assign id_to_ex_dest       = writes_rd ? id_inst[11:7] : '0;
  assign id_to_ex_a          = rs1_data;
  assign id_to_ex_store_data = rs2_data;

  always_ff @(posedge clock) begin
    if (reset) begin
      id_valid <= 1'b0;
    end else if (id_allowin) begin
      id_valid <= if_to_id_valid & ~branch_taken;
    end
  end

  // wrong-path slot after a taken branch becomes a nop
  always_ff @(posedge clock) begin
    if (id_allowin && if_to_id_valid) begin
      id_pc   <= if_to_id_pc;
      id_inst <= branch_taken ? nop_inst : if_to_id_inst;
    end
  end

endmodule

`default_nettype wire

/* regfile.sv */
// integer register file
`default_nettype none

module regfile
  import cpu_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  reg_idx_t rs1_addr,
  output word_t    rs1_data,
  input  reg_idx_t rs2_addr,
  output word_t    rs2_data,
  input  logic     wr_ena,
  input  reg_idx_t wr_addr,
  input  word_t    wr_data
);

  word_t regs [32];

  // x0 reads zero, a same-cycle write is passed straight through
  function automatic word_t read_port(input reg_idx_t addr);
    if (addr == '0) begin
      return '0;
    end
    if (wr_ena && (wr_addr == addr)) begin
      return wr_data;
    end
    return regs[addr];
  endfunction

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ena && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

endmodule

`default_nettype wire

/* ex_stage.sv */
// execute stage
`default_nettype none

module ex_stage
  import cpu_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     id_to_ex_valid,
  input  word_t    id_to_ex_pc,
  input  op_kind_e id_to_ex_kind,
  input  alu_op_e  id_to_ex_alu_op,
  input  reg_idx_t id_to_ex_dest,
  input  word_t    id_to_ex_a,
  input  word_t    id_to_ex_b,
  input  word_t    id_to_ex_store_data,
  output logic     ex_allowin,
  input  logic     mem_allowin,
  output logic     ex_to_mem_valid,
  output op_kind_e ex_to_mem_kind,
  output reg_idx_t ex_to_mem_dest,
  output word_t    ex_to_mem_result,
  output word_t    ex_to_mem_store_data,
  output logic     ex_pend_valid,
  output reg_idx_t ex_pend_dest
);

  logic     ex_valid;
  op_kind_e ex_kind;
  reg_idx_t ex_dest;
  word_t    ex_result;
  word_t    ex_store_data;
  word_t    alu_out;
  word_t    result;

  always_comb begin
    case (id_to_ex_alu_op)
      alu_sub: alu_out = id_to_ex_a - id_to_ex_b;
      alu_and: alu_out = id_to_ex_a & id_to_ex_b;
      alu_or:  alu_out = id_to_ex_a | id_to_ex_b;
      alu_xor: alu_out = id_to_ex_a ^ id_to_ex_b;
      alu_slt: alu_out = {63'd0, $signed(id_to_ex_a) < $signed(id_to_ex_b)};
      default: alu_out = id_to_ex_a + id_to_ex_b;
    endcase
  end

  // load/store address and putch byte both come out of the adder
  always_comb begin
    case (id_to_ex_kind)
      op_lui:             result = id_to_ex_b;
      // no register write here, keep the pc for tracing
      op_branch, op_none: result = id_to_ex_pc;
      default:            result = alu_out;
    endcase
  end

  // single-cycle stage
  assign ex_allowin = ~ex_valid | mem_allowin;

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_valid <= 1'b0;
    end else if (ex_allowin) begin
      ex_valid <= id_to_ex_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (ex_allowin && id_to_ex_valid) begin
      ex_kind       <= id_to_ex_kind;
      ex_dest       <= id_to_ex_dest;
      ex_result     <= result;
      ex_store_data <= id_to_ex_store_data;
    end
  end

  assign ex_to_mem_valid      = ex_valid;
  assign ex_to_mem_kind       = ex_kind;
  assign ex_to_mem_dest       = ex_dest;
  assign ex_to_mem_result     = ex_result;
  assign ex_to_mem_store_data = ex_store_data;
  assign ex_pend_valid        = ex_valid;
  assign ex_pend_dest         = ex_dest;

endmodule

`default_nettype wire

/* mem_stage.sv */
// memory access stage
`default_nettype none

module mem_stage
  import cpu_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     ex_to_mem_valid,
  input  op_kind_e ex_to_mem_kind,
  input  reg_idx_t ex_to_mem_dest,
  input  word_t    ex_to_mem_result,
  input  word_t    ex_to_mem_store_data,
  output logic     mem_allowin,
  input  logic     wb_allowin,
  output logic     mem_to_wb_valid,
  output op_kind_e mem_to_wb_kind,
  output reg_idx_t mem_to_wb_dest,
  output word_t    mem_to_wb_value,
  output logic     mem_pend_valid,
  output reg_idx_t mem_pend_dest,
  output logic     mem_rw_valid,
  input  logic     mem_rw_ready,
  output logic     mem_rw_req,
  output word_t    mem_rw_addr,
  output word_t    mem_w_data,
  input  word_t    mem_r_data
);

  logic     mem_valid;
  logic     done_q;
  op_kind_e mem_kind;
  reg_idx_t mem_dest;
  word_t    mem_result;
  word_t    mem_store_data;
  word_t    load_q;
  logic     is_access;
  logic     fire;
  logic     ready_go;

  assign is_access = (mem_kind == op_load) || (mem_kind == op_store);

  // one request per access, dropped once it has completed
  assign mem_rw_valid = mem_valid & is_access & ~done_q;
  assign mem_rw_req   = (mem_kind == op_store);
  assign mem_rw_addr  = mem_result;
  assign mem_w_data   = mem_store_data;
  assign fire         = mem_rw_valid & mem_rw_ready;

  assign ready_go        = ~is_access | done_q | fire;
  assign mem_allowin     = ~mem_valid | (ready_go & wb_allowin);
  assign mem_to_wb_valid = mem_valid & ready_go;

  always_ff @(posedge clock) begin
    if (reset) begin
      mem_valid <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      if (mem_allowin) begin
        mem_valid <= ex_to_mem_valid;
        done_q    <= 1'b0;
      end else if (fire) begin
        done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (mem_allowin && ex_to_mem_valid) begin
      mem_kind       <= ex_to_mem_kind;
      mem_dest       <= ex_to_mem_dest;
      mem_result     <= ex_to_mem_result;
      mem_store_data <= ex_to_mem_store_data;
    end
    if (fire) begin
      load_q <= mem_r_data;
    end
  end

  // load data is live on the ready cycle, held afterwards
  always_comb begin
    if (mem_kind == op_load) begin
      mem_to_wb_value = done_q ? load_q : mem_r_data;
    end else begin
      mem_to_wb_value = mem_result;
    end
  end

  assign mem_to_wb_kind = mem_kind;
  assign mem_to_wb_dest = mem_dest;
  assign mem_pend_valid = mem_valid;
  assign mem_pend_dest  = mem_dest;

endmodule

`default_nettype wire

/* wb_stage.sv */
// writeback stage
`default_nettype none

module wb_stage
  import cpu_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     mem_to_wb_valid,
  input  op_kind_e mem_to_wb_kind,
  input  reg_idx_t mem_to_wb_dest,
  input  word_t    mem_to_wb_value,
  output logic     wb_allowin,
  output logic     wr_ena,
  output reg_idx_t wr_addr,
  output word_t    wr_data,
  output logic     wb_pend_valid,
  output reg_idx_t wb_pend_dest,
  output logic     uart_out_valid,
  output logic [7:0] uart_out_char
);

  logic     wb_valid;
  op_kind_e wb_kind;
  reg_idx_t wb_dest;
  word_t    wb_value;

  // retires in one cycle, never back-pressures
  assign wb_allowin = 1'b1;

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= mem_to_wb_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (mem_to_wb_valid) begin
      wb_kind  <= mem_to_wb_kind;
      wb_dest  <= mem_to_wb_dest;
      wb_value <= mem_to_wb_value;
    end
  end

  assign wr_ena  = wb_valid && (wb_kind inside {op_alu_reg, op_alu_imm, op_lui, op_load});
  assign wr_addr = wb_dest;
  assign wr_data = wb_value;

  assign wb_pend_valid = wb_valid;
  assign wb_pend_dest  = wb_dest;

  // one pulse per retired putch
  assign uart_out_valid = wb_valid && (wb_kind == op_putch);
  assign uart_out_char  = wb_value[7:0];

endmodule

`default_nettype wire

/* cpu.sv */
// five-stage rv64i core
`default_nettype none

module cpu
  import cpu_pkg::*;
#(
  parameter word_t RESET_PC = 64'h0000_0000_8000_0000
) (
  input  logic       clock,
  input  logic       reset,
  // instruction fetch port
  output logic       if_rw_valid,
  input  logic       if_rw_ready,
  input  inst_t      if_r_data,
  output word_t      if_rw_addr,
  // data memory port
  output logic       mem_rw_valid,
  input  logic       mem_rw_ready,
  output logic       mem_rw_req,
  input  word_t      mem_r_data,
  output word_t      mem_w_data,
  output word_t      mem_rw_addr,
  // serial output
  output logic       uart_out_valid,
  output logic [7:0] uart_out_char
);

  // fetch to decode
  logic     if_to_id_valid;
  word_t    if_to_id_pc;
  inst_t    if_to_id_inst;
  logic     id_allowin;
  logic     branch_taken;
  word_t    branch_target;

  // decode to execute
  logic     id_to_ex_valid;
  word_t    id_to_ex_pc;
  op_kind_e id_to_ex_kind;
  alu_op_e  id_to_ex_alu_op;
  reg_idx_t id_to_ex_dest;
  word_t    id_to_ex_a;
  word_t    id_to_ex_b;
  word_t    id_to_ex_store_data;
  logic     ex_allowin;

  // execute to memory
  logic     ex_to_mem_valid;
  op_kind_e ex_to_mem_kind;
  reg_idx_t ex_to_mem_dest;
  word_t    ex_to_mem_result;
  word_t    ex_to_mem_store_data;
  logic     mem_allowin;

  // memory to writeback
  logic     mem_to_wb_valid;
  op_kind_e mem_to_wb_kind;
  reg_idx_t mem_to_wb_dest;
  word_t    mem_to_wb_value;
  logic     wb_allowin;

  // interlock sources
  logic     ex_pend_valid;
  reg_idx_t ex_pend_dest;
  logic     mem_pend_valid;
  reg_idx_t mem_pend_dest;
  logic     wb_pend_valid;
  reg_idx_t wb_pend_dest;

  // register file ports
  reg_idx_t rs1_addr;
  reg_idx_t rs2_addr;
  word_t    rs1_data;
  word_t    rs2_data;
  logic     wr_ena;
  reg_idx_t wr_addr;
  word_t    wr_data;

  // port names match the wires above
  if_stage #(
    .RESET_PC (RESET_PC)
  ) u_if_stage (.*);

  id_stage u_id_stage (.*);

  regfile u_regfile (.*);

  ex_stage u_ex_stage (.*);

  mem_stage u_mem_stage (.*);

  wb_stage u_wb_stage (.*);

endmodule

`default_nettype wire

/* cpu_checker.sv */
// port protocol assertions
`default_nettype none

module cpu_checker
  import cpu_pkg::*;
(
  input logic       clock,
  input logic       reset,
  input logic       if_rw_valid,
  input logic       if_rw_ready,
  input word_t      if_rw_addr,
  input logic       mem_rw_valid,
  input logic       mem_rw_ready,
  input logic       mem_rw_req,
  input word_t      mem_rw_addr,
  input word_t      mem_w_data,
  input logic       uart_out_valid,
  input logic [7:0] uart_out_char
);

  // number of failed assertions
  int unsigned fail_count = 0;

  // fetch request held until ready
  fetch_hold: assert property (@(posedge clock) disable iff (reset)
    if_rw_valid && !if_rw_ready |=> if_rw_valid && $stable(if_rw_addr))
  else begin
    fail_count++;
    $error("fetch request dropped or moved before ready");
  end

  // data request and its payload held until ready
  data_hold: assert property (@(posedge clock) disable iff (reset)
    mem_rw_valid && !mem_rw_ready |=>
      mem_rw_valid && $stable({mem_rw_req, mem_rw_addr, mem_w_data}))
  else begin
    fail_count++;
    $error("data request dropped or changed before ready");
  end

  fetch_align: assert property (@(posedge clock) disable iff (reset)
    if_rw_valid |-> if_rw_addr[1:0] == 2'b00)
  else begin
    fail_count++;
    $error("fetch address not word aligned");
  end

  // outputs stay quiet while reset is applied
  reset_quiet: assert property (@(posedge clock)
    reset |=> !if_rw_valid && !mem_rw_valid && !uart_out_valid)
  else begin
    fail_count++;
    $error("valid output high during reset");
  end

  valids_known: assert property (@(posedge clock) disable iff (reset)
    !$isunknown({if_rw_valid, mem_rw_valid, uart_out_valid}))
  else begin
    fail_count++;
    $error("valid output unknown after reset");
  end

  payload_known: assert property (@(posedge clock) disable iff (reset)
    (!if_rw_valid || !$isunknown(if_rw_addr)) &&
    (!mem_rw_valid || !$isunknown({mem_rw_req, mem_rw_addr})) &&
    (!uart_out_valid || !$isunknown(uart_out_char)))
  else begin
    fail_count++;
    $error("request payload unknown while valid");
  end

endmodule

bind cpu cpu_checker u_checker (
  .clock          (clock),
  .reset          (reset),
  .if_rw_valid    (if_rw_valid),
  .if_rw_ready    (if_rw_ready),
  .if_rw_addr     (if_rw_addr),
  .mem_rw_valid   (mem_rw_valid),
  .mem_rw_ready   (mem_rw_ready),
  .mem_rw_req     (mem_rw_req),
  .mem_rw_addr    (mem_rw_addr),
  .mem_w_data     (mem_w_data),
  .uart_out_valid (uart_out_valid),
  .uart_out_char  (uart_out_char)
);

`default_nettype wire

/* clock_gen.sv */
// testbench clock source
`default_nettype none

module clock_gen #(
  parameter int PERIOD = 40
) (
  output logic clock
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

endmodule

`default_nettype wire

/* tb_cpu.sv */
// cpu testbench
`default_nettype none

module tb_cpu
  import cpu_pkg::*;
();

  localparam word_t       RESET_PC     = 64'h0000_0000_8000_0000;
  localparam int unsigned SEED         = 32'hf52949b7;
  localparam int          RESET_CYCLES = 16;
  localparam int          DRAIN_CYCLES = 20;
  localparam int          CYCLES_PER_INST = 200;

  logic       clock;
  logic       reset;
  logic       if_rw_valid;
  logic       if_rw_ready;
  inst_t      if_r_data;
  word_t      if_rw_addr;
  logic       mem_rw_valid;
  logic       mem_rw_ready;
  logic       mem_rw_req;
  word_t      mem_r_data;
  word_t      mem_w_data;
  word_t      mem_rw_addr;
  logic       uart_out_valid;
  logic [7:0] uart_out_char;

  inst_t      rom [$];
  word_t      data_mem [word_t];
  logic [7:0] exp_char [$];
  string      char_test [$];
  word_t      exp_addr [$];
  word_t      exp_data [$];
  string      store_test [$];
  int         chars_seen = 0;
  int         stores_seen = 0;
  int         errors = 0;
  int         fetch_wait = -1;
  int         data_wait = -1;
  logic       first_fetch = 1'b1;

  clock_gen #(
    .PERIOD (40)
  ) u_clock_gen (
    .clock (clock)
  );

  cpu #(
    .RESET_PC (RESET_PC)
  ) u_cpu (.*);

  // rv64i encodings
  function automatic inst_t reg_op(input logic [6:0] funct7, input logic [2:0] funct3,
                                   input logic [4:0] rd, input logic [4:0] rs1,
                                   input logic [4:0] rs2);
    return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
  endfunction

  function automatic inst_t addi(input logic [4:0] rd, input logic [4:0] rs1,
                                 input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic inst_t lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic inst_t ld(input logic [4:0] rd, input logic [4:0] rs1,
                               input logic [11:0] imm);
    return {imm, rs1, 3'b011, rd, 7'b0000011};
  endfunction

  function automatic inst_t sd(input logic [4:0] rs2, input logic [4:0] rs1,
                               input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
  endfunction

  function automatic inst_t branch(input logic [2:0] funct3, input logic [4:0] rs1,
                                   input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, funct3, off[4:1], off[11], 7'b1100011};
  endfunction

  // custom opcode, low byte of rs1 to the serial port
  function automatic inst_t putch(input logic [4:0] rs1);
    return {12'h000, rs1, 3'b000, 5'd0, 7'b1111011};
  endfunction

  // contents of data words never stored
  function automatic word_t fill_word(input word_t addr);
    return addr ^ {addr[31:0], addr[63:32]} ^ 64'ha5a5_5a5a_c3c3_3c3c;
  endfunction

  task automatic load_program();
    rom.push_back(addi(1, 0, 12'h041));
    rom.push_back(putch(1));
    rom.push_back(addi(2, 1, 12'h001));
    rom.push_back(putch(2));
    rom.push_back(reg_op(7'h00, 3'b000, 3, 1, 2));
    rom.push_back(putch(3));
    rom.push_back(reg_op(7'h20, 3'b000, 4, 3, 2));
    rom.push_back(putch(4));
    rom.push_back(reg_op(7'h00, 3'b111, 5, 3, 2));
    rom.push_back(putch(5));
    rom.push_back(reg_op(7'h00, 3'b110, 6, 5, 1));
    rom.push_back(putch(6));
    rom.push_back(reg_op(7'h00, 3'b100, 7, 6, 2));
    rom.push_back(putch(7));
    // signed compare against -1
    rom.push_back(addi(9, 0, 12'hfff));
    rom.push_back(reg_op(7'h00, 3'b010, 10, 9, 1));
    rom.push_back(putch(10));
    rom.push_back(reg_op(7'h00, 3'b010, 11, 1, 9));
    rom.push_back(putch(11));
    rom.push_back(lui(13, 20'h12345));
    rom.push_back(addi(13, 13, 12'h067));
    rom.push_back(putch(13));
    rom.push_back(lui(14, 20'h80000));
    rom.push_back(addi(20, 0, 12'h400));
    rom.push_back(sd(13, 20, 12'h008));
    rom.push_back(sd(14, 20, 12'h010));
    rom.push_back(sd(1, 20, 12'hff8));
    // load-use right after the load
    rom.push_back(ld(15, 20, 12'h008));
    rom.push_back(putch(15));
    rom.push_back(ld(16, 20, 12'hff8));
    rom.push_back(putch(16));
    // two taken, two not taken
    rom.push_back(branch(3'b000, 1, 1, 13'd8));
    rom.push_back(putch(5));
    rom.push_back(branch(3'b001, 1, 2, 13'd8));
    rom.push_back(putch(7));
    rom.push_back(branch(3'b000, 1, 2, 13'd8));
    rom.push_back(putch(6));
    rom.push_back(branch(3'b001, 1, 1, 13'd8));
    rom.push_back(putch(1));
    rom.push_back(addi(17, 0, 12'h02e));
    rom.push_back(putch(17));
    rom.push_back(branch(3'b000, 0, 0, 13'd0));
  endtask

  task automatic expect_char(input string name, input logic [7:0] c);
    exp_char.push_back(c);
    char_test.push_back(name);
  endtask

  task automatic expect_store(input string name, input word_t addr, input word_t data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    store_test.push_back(name);
  endtask

  task automatic load_expected();
    expect_char("addi", 8'h41);
    expect_char("addi dependent", 8'h42);
    expect_char("add", 8'h83);
    expect_char("sub", 8'h41);
    expect_char("and", 8'h02);
    expect_char("or", 8'h43);
    expect_char("xor", 8'h01);
    expect_char("slt negative", 8'h01);
    expect_char("slt positive", 8'h00);
    expect_char("lui addi", 8'h67);
    expect_char("ld after sd", 8'h67);
    expect_char("ld negative offset", 8'h41);
    expect_char("beq not taken", 8'h43);
    expect_char("bne not taken", 8'h41);
    expect_char("end marker", 8'h2e);
    expect_store("sd", 64'h0000_0000_0000_0408, 64'h0000_0000_1234_5067);
    expect_store("sd lui sign", 64'h0000_0000_0000_0410, 64'hffff_ffff_8000_0000);
    expect_store("sd negative offset", 64'h0000_0000_0000_03f8, 64'h0000_0000_0000_0041);
  endtask

  task automatic serve_fetch();
    word_t idx;
    if_rw_ready <= 1'b0;
    if (!reset && if_rw_valid) begin
      if (first_fetch) begin
        first_fetch = 1'b0;
        assert (if_rw_addr == RESET_PC) else begin
          errors++;
          $display("Fail reset: expected first fetch %h, actual %h", RESET_PC, if_rw_addr);
        end
      end
      if (fetch_wait < 0) begin
        fetch_wait = $urandom % 4;
      end
      if (fetch_wait == 0) begin
        idx = (if_rw_addr - RESET_PC) >> 2;
        if_rw_ready <= 1'b1;
        // past the image the core only sees nops
        if (idx < rom.size()) begin
          if_r_data <= rom[idx];
        end else begin
          if_r_data <= 32'h0000_0013;
        end
        fetch_wait = -1;
      end else begin
        fetch_wait--;
      end
    end
  endtask

  task automatic check_store();
    assert (stores_seen < exp_addr.size()) else begin
      errors++;
      $display("unexpected extra store to %h with data %h", mem_rw_addr, mem_w_data);
    end
    if (stores_seen < exp_addr.size()) begin
      assert (mem_rw_addr == exp_addr[stores_seen]) else begin
        errors++;
        $display("Fail %s: expected address %h, actual %h", store_test[stores_seen],
                 exp_addr[stores_seen], mem_rw_addr);
      end
      assert (mem_w_data == exp_data[stores_seen]) else begin
        errors++;
        $display("Fail %s: expected data %h, actual %h", store_test[stores_seen],
                 exp_data[stores_seen], mem_w_data);
      end
    end
    stores_seen++;
  endtask

  // request payload is held until ready, so it is taken here
  task automatic serve_data();
    mem_rw_ready <= 1'b0;
    if (!reset && mem_rw_valid) begin
      if (data_wait < 0) begin
        data_wait = $urandom % 4;
      end
      if (data_wait == 0) begin
        mem_rw_ready <= 1'b1;
        data_wait = -1;
        if (mem_rw_req) begin
          check_store();
          data_mem[mem_rw_addr] = mem_w_data;
        end else if (data_mem.exists(mem_rw_addr)) begin
          mem_r_data <= data_mem[mem_rw_addr];
        end else begin
          mem_r_data <= fill_word(mem_rw_addr);
        end
      end else begin
        data_wait--;
      end
    end
  endtask

  task automatic sample_serial();
    if (!reset && uart_out_valid) begin
      assert (chars_seen < exp_char.size()) else begin
        errors++;
        $display("unexpected extra serial character %h", uart_out_char);
      end
      if (chars_seen < exp_char.size()) begin
        assert (uart_out_char == exp_char[chars_seen]) else begin
          errors++;
          $display("Fail %s: expected %h, actual %h", char_test[chars_seen],
                   exp_char[chars_seen], uart_out_char);
        end
      end
      chars_seen++;
    end
  endtask

  task automatic finish_run();
    int checker_errors;
    checker_errors = u_cpu.u_checker.fail_count;
    $display("errors: testbench %0d, checker %0d, chars %0d of %0d, stores %0d of %0d",
             errors, checker_errors, chars_seen, exp_char.size(), stores_seen,
             exp_addr.size());
    if (errors == 0 && checker_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  // memory models and serial monitor, all on the falling edge
  initial begin
    void'($urandom(SEED));
    if_rw_ready  = 1'b0;
    if_r_data    = '0;
    mem_rw_ready = 1'b0;
    mem_r_data   = '0;
    forever begin
      @(negedge clock);
      serve_fetch();
      serve_data();
      sample_serial();
    end
  end

  initial begin
    reset = 1'b1;
    load_program();
    load_expected();
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset <= 1'b0;
    while (chars_seen < exp_char.size() || stores_seen < exp_addr.size()) begin
      @(negedge clock);
    end
    // late duplicates would show up here
    repeat (DRAIN_CYCLES) @(negedge clock);
    assert (chars_seen == exp_char.size() && stores_seen == exp_addr.size()) else begin
      errors++;
      $display("serial or store count differs from the expected lists");
    end
    finish_run();
  end

  initial begin
    @(negedge reset);
    repeat (rom.size() * CYCLES_PER_INST) @(posedge clock);
    errors++;
    $display("watchdog expired after %0d cycles, the program did not finish",
             rom.size() * CYCLES_PER_INST);
    finish_run();
  end

endmodule

`default_nettype wire

/* all.f */
cpu_pkg.sv
if_stage.sv
id_stage.sv
regfile.sv
ex_stage.sv
mem_stage.sv
wb_stage.sv
cpu.sv
cpu_checker.sv
clock_gen.sv
tb_cpu.sv

/* Makefile */
TOP = tb_cpu

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): all.f $(wildcard *.sv)
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f all.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -qF '*** PASSED ***' sim.log

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir sim.log
